// File: flist.f
logic/nrisc_isa_pkg.sv
logic/nrisc_ctrl_pkg.sv
logic/nrisc_decode.sv
logic/nrisc_sequencer.sv
logic/nrisc_ctrl_top.sv
tb/nrisc_ctrl_tb.sv

// File: logic/nrisc_ctrl_pkg.sv
// Control encoding: ALU codes, phase codes, stack ops, PC selects and flag indices
package nrisc_ctrl_pkg;

  // ALU operation codes
  localparam int ALU_CTRL_W  = 4;
  localparam int ALU_ROT_BIT = 3;  // Set on SHR/SHL turns them into rotates

  localparam logic [ALU_CTRL_W-1:0] ALU_ADD = 4'h0;
  localparam logic [ALU_CTRL_W-1:0] ALU_SUB = 4'h1;
  localparam logic [ALU_CTRL_W-1:0] ALU_AND = 4'h2;
  localparam logic [ALU_CTRL_W-1:0] ALU_OR  = 4'h3;
  localparam logic [ALU_CTRL_W-1:0] ALU_XOR = 4'h4;
  localparam logic [ALU_CTRL_W-1:0] ALU_SHR = 4'h5;
  localparam logic [ALU_CTRL_W-1:0] ALU_SHL = 4'h6;
  localparam logic [ALU_CTRL_W-1:0] ALU_NOT = 4'h7;

  // Instruction phases
  // The same codes drive the PC source mux
  //   PH_EXEC  PC + 1
  //   PH_JUMP  ALU result
  //   PH_RET   top of stack
  localparam int PHASE_W = 2;

  localparam logic [PHASE_W-1:0] PH_EXEC = 2'd0;  // Decode and execute
  localparam logic [PHASE_W-1:0] PH_MEM  = 2'd1;  // Data memory access, LW/SW
  localparam logic [PHASE_W-1:0] PH_JUMP = 2'd2;  // PC load from ALU
  localparam logic [PHASE_W-1:0] PH_RET  = 2'd3;  // PC load from stack

  // Stack operations
  localparam int STACK_W = 2;

  localparam logic [STACK_W-1:0] STK_NONE = 2'd0;
  localparam logic [STACK_W-1:0] STK_PUSH = 2'd1;  // CALL saves return address
  localparam logic [STACK_W-1:0] STK_POP  = 2'd2;  // RET and RETI

  // ALU flag vector
  localparam int FLAG_W = 3;

  localparam int FLAG_MINUS = 0;  // Result negative, JM
  localparam int FLAG_ZERO  = 1;  // Result zero, JZ
  localparam int FLAG_CARRY = 2;  // Carry out, JC

endpackage

// File: logic/nrisc_ctrl_top.sv
// Control unit top level connecting the decoder to the phase sequencer
`timescale 1ns/1ps

module nrisc_ctrl_top (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [nrisc_isa_pkg::INSTR_W-1:0]       instr,    // Stable for the whole instruction
  input  logic [nrisc_ctrl_pkg::FLAG_W-1:0]       flags,    // Sampled in PH_EXEC
  output logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0]   alu_ctrl,
  output logic                                    inc_dec_sel,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    rd_addr,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    rf1_addr,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    rf2_addr,
  output logic                                    imm_to_reg,
  output logic                                    data_to_reg,
  output logic                                    reg_write,
  output logic                                    data_addr_strobe,
  output logic                                    data_write,
  output logic [nrisc_ctrl_pkg::STACK_W-1:0]      stack_op,
  output logic [nrisc_ctrl_pkg::PHASE_W-1:0]      pc_sel,
  output logic                                    pc_strobe,
  output logic [nrisc_ctrl_pkg::PHASE_W-1:0]      phase
);

  // Decoder requests
  logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0] alu_code;
  logic                                  inc_dec;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  dst;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  src1;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  src2;
  logic                                  imm_sel;
  logic                                  load_sel;
  logic                                  exec_write;
  logic [nrisc_ctrl_pkg::PHASE_W-1:0]    next_phase;
  logic [nrisc_ctrl_pkg::STACK_W-1:0]    stack_req;
  logic                                  is_store;

  nrisc_decode decode_i (
    .instr      (instr),  // Raw word viewed through instr_t
    .flags      (flags),
    .alu_code   (alu_code),
    .inc_dec    (inc_dec),
    .dst        (dst),
    .src1       (src1),
    .src2       (src2),
    .imm_sel    (imm_sel),
    .load_sel   (load_sel),
    .exec_write (exec_write),
    .next_phase (next_phase),
    .stack_req  (stack_req),
    .is_store   (is_store)
  );

  nrisc_sequencer sequencer_i (
    .clk              (clk),
    .reset            (reset),
    .alu_code         (alu_code),
    .inc_dec          (inc_dec),
    .dst              (dst),
    .src1             (src1),
    .src2             (src2),
    .imm_sel          (imm_sel),
    .load_sel         (load_sel),
    .exec_write       (exec_write),
    .next_phase       (next_phase),
    .stack_req        (stack_req),
    .is_store         (is_store),
    .alu_ctrl         (alu_ctrl),
    .inc_dec_sel      (inc_dec_sel),
    .rd_addr          (rd_addr),
    .rf1_addr         (rf1_addr),
    .rf2_addr         (rf2_addr),
    .imm_to_reg       (imm_to_reg),
    .data_to_reg      (data_to_reg),
    .reg_write        (reg_write),
    .data_addr_strobe (data_addr_strobe),
    .data_write       (data_write),
    .stack_op         (stack_op),
    .pc_sel           (pc_sel),
    .pc_strobe        (pc_strobe),
    .phase            (phase)
  );

endmodule

// File: logic/nrisc_decode.sv
// Combinational instruction decoder producing control requests for the sequencer
`timescale 1ns/1ps

module nrisc_decode (
  input  nrisc_isa_pkg::instr_t                         instr,
  input  logic [nrisc_ctrl_pkg::FLAG_W-1:0]             flags,
  output logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0]         alu_code,
  output logic                                          inc_dec,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]          dst,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]          src1,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]          src2,
  output logic                                          imm_sel,
  output logic                                          load_sel,
  output logic                                          exec_write,
  output logic [nrisc_ctrl_pkg::PHASE_W-1:0]            next_phase,
  output logic [nrisc_ctrl_pkg::STACK_W-1:0]            stack_req,
  output logic                                          is_store
);

  always_comb begin
    // Plain single-phase no-op unless an opcode says otherwise
    alu_code   = nrisc_ctrl_pkg::ALU_ADD;  // Also the address adder for LW/SW/jumps
    inc_dec    = 1'b0;
    dst        = instr.r.dst;
    src1       = instr.r.src1;
    src2       = instr.r.src2;
    imm_sel    = 1'b0;
    load_sel   = 1'b0;
    exec_write = 1'b0;
    next_phase = nrisc_ctrl_pkg::PH_EXEC;
    stack_req  = nrisc_ctrl_pkg::STK_NONE;
    is_store   = 1'b0;

    case (instr.r.opcode)
      nrisc_isa_pkg::OP_SYS: begin
        // Target address is src1 + src2 on the ALU
        case (instr.s.sub)
          nrisc_isa_pkg::SYS_CALL: begin
            next_phase = nrisc_ctrl_pkg::PH_JUMP;
            stack_req  = nrisc_ctrl_pkg::STK_PUSH;
          end
          nrisc_isa_pkg::SYS_RET,
          nrisc_isa_pkg::SYS_RETI: begin
            next_phase = nrisc_ctrl_pkg::PH_RET;   // PC comes back off the stack
            stack_req  = nrisc_ctrl_pkg::STK_POP;
          end
          default: ;  // HALT, WAIT, SLEEP and the rest fall through as no-ops
        endcase
      end

      // Memory group
      nrisc_isa_pkg::OP_LW: begin
        load_sel   = 1'b1;  // Register gets data memory, written in PH_MEM
        next_phase = nrisc_ctrl_pkg::PH_MEM;
      end
      nrisc_isa_pkg::OP_SW: begin
        is_store   = 1'b1;  // dst field names the register being stored
        next_phase = nrisc_ctrl_pkg::PH_MEM;
      end
      nrisc_isa_pkg::OP_LI: begin
        // Destination sits in the same field as the register form
        imm_sel    = 1'b1;  // Low byte of instr to the write port
        exec_write = 1'b1;
      end

      // Jumps, taken ones go through PH_JUMP
      nrisc_isa_pkg::OP_JMP: next_phase = nrisc_ctrl_pkg::PH_JUMP;
      nrisc_isa_pkg::OP_JZ: begin
        if (flags[nrisc_ctrl_pkg::FLAG_ZERO])
          next_phase = nrisc_ctrl_pkg::PH_JUMP;
      end
      nrisc_isa_pkg::OP_JC: begin
        if (flags[nrisc_ctrl_pkg::FLAG_CARRY])
          next_phase = nrisc_ctrl_pkg::PH_JUMP;
      end
      nrisc_isa_pkg::OP_JM: begin
        if (flags[nrisc_ctrl_pkg::FLAG_MINUS])
          next_phase = nrisc_ctrl_pkg::PH_JUMP;
      end

      // Two-operand ALU group
      nrisc_isa_pkg::OP_ADD: exec_write = 1'b1;
      nrisc_isa_pkg::OP_SUB: begin
        alu_code   = nrisc_ctrl_pkg::ALU_SUB;
        exec_write = 1'b1;
      end
      nrisc_isa_pkg::OP_AND: begin
        alu_code   = nrisc_ctrl_pkg::ALU_AND;
        exec_write = 1'b1;
      end
      nrisc_isa_pkg::OP_OR: begin
        alu_code   = nrisc_ctrl_pkg::ALU_OR;
        exec_write = 1'b1;
      end
      nrisc_isa_pkg::OP_XOR: begin
        alu_code   = nrisc_ctrl_pkg::ALU_XOR;
        exec_write = 1'b1;
      end

      // Shifts, instr bit 0 turns them into rotates
      nrisc_isa_pkg::OP_SHR: begin
        alu_code = nrisc_ctrl_pkg::ALU_SHR;
        alu_code[nrisc_ctrl_pkg::ALU_ROT_BIT] = instr.r.src2[0];
        exec_write = 1'b1;
      end
      nrisc_isa_pkg::OP_SHL: begin
        alu_code = nrisc_ctrl_pkg::ALU_SHL;
        alu_code[nrisc_ctrl_pkg::ALU_ROT_BIT] = instr.r.src2[0];
        exec_write = 1'b1;
      end

      // Unary group, sub-opcode sits in the src2 field
      nrisc_isa_pkg::OP_UNARY: begin
        case (instr.r.src2)
          nrisc_isa_pkg::UN_NOT: begin
            alu_code   = nrisc_ctrl_pkg::ALU_NOT;
            exec_write = 1'b1;
          end
          nrisc_isa_pkg::UN_INC: begin
            inc_dec    = 1'b1;  // ALU B input forced to one
            exec_write = 1'b1;
          end
          nrisc_isa_pkg::UN_DEC: begin
            alu_code   = nrisc_ctrl_pkg::ALU_SUB;
            inc_dec    = 1'b1;
            exec_write = 1'b1;
          end
          default: ;  // TWC and unused slots
        endcase
      end

      default: ;
    endcase
  end

endmodule

// File: logic/nrisc_isa_pkg.sv
// Instruction-set encoding: opcodes, sub-opcodes, field widths and the instruction word union
package nrisc_isa_pkg;

  // Field widths
  localparam int INSTR_W    = 16;
  localparam int OP_W       = 4;
  localparam int REG_ADDR_W = 4;
  localparam int SUB_W      = 4;  // System sub-opcode field
  localparam int IMM_W      = 8;  // LI immediate

  // Main opcodes, instr[15:12]
  localparam logic [OP_W-1:0] OP_SYS   = 4'h0;  // System group, sub-opcode in [11:8]
  localparam logic [OP_W-1:0] OP_LW    = 4'h1;
  localparam logic [OP_W-1:0] OP_SW    = 4'h2;
  localparam logic [OP_W-1:0] OP_LI    = 4'h3;
  localparam logic [OP_W-1:0] OP_JMP   = 4'h4;
  localparam logic [OP_W-1:0] OP_JZ    = 4'h5;
  localparam logic [OP_W-1:0] OP_JC    = 4'h6;
  localparam logic [OP_W-1:0] OP_JM    = 4'h7;
  localparam logic [OP_W-1:0] OP_ADD   = 4'h8;  // ALU class starts here, bit 15 set
  localparam logic [OP_W-1:0] OP_SUB   = 4'h9;
  localparam logic [OP_W-1:0] OP_AND   = 4'hA;
  localparam logic [OP_W-1:0] OP_OR    = 4'hB;
  localparam logic [OP_W-1:0] OP_XOR   = 4'hC;
  localparam logic [OP_W-1:0] OP_SHR   = 4'hD;  // Bit 0 picks rotate
  localparam logic [OP_W-1:0] OP_SHL   = 4'hE;  // Bit 0 picks rotate
  localparam logic [OP_W-1:0] OP_UNARY = 4'hF;  // Sub-opcode in [3:0]

  // System sub-opcodes
  // 0 to 3 were NOT, HALT, WAIT, SLEEP and decode as no-ops
  localparam logic [SUB_W-1:0] SYS_CALL = 4'h4;
  localparam logic [SUB_W-1:0] SYS_RET  = 4'h5;
  localparam logic [SUB_W-1:0] SYS_RETI = 4'h6;

  // Unary sub-opcodes, 1 is the unused two's complement slot
  localparam logic [REG_ADDR_W-1:0] UN_NOT = 4'h0;
  localparam logic [REG_ADDR_W-1:0] UN_INC = 4'h2;
  localparam logic [REG_ADDR_W-1:0] UN_DEC = 4'h3;

  // Register form, ALU ops, LW/SW and jumps
  typedef struct packed {
    logic [OP_W-1:0]       opcode;
    logic [REG_ADDR_W-1:0] dst;
    logic [REG_ADDR_W-1:0] src1;
    logic [REG_ADDR_W-1:0] src2;
  } reg_form_t;

  // System form, CALL/RET/RETI
  typedef struct packed {
    logic [OP_W-1:0]       opcode;
    logic [SUB_W-1:0]      sub;
    logic [REG_ADDR_W-1:0] src1;
    logic [REG_ADDR_W-1:0] src2;
  } sys_form_t;

  // Immediate form, LI only
  typedef struct packed {
    logic [OP_W-1:0]       opcode;
    logic [REG_ADDR_W-1:0] dst;
    logic [IMM_W-1:0]      imm;
  } imm_form_t;

  // One instruction word, three views
  typedef union packed {
    reg_form_t r;
    sys_form_t s;
    imm_form_t i;
  } instr_t;

endpackage

// File: logic/nrisc_sequencer.sv
// Phase FSM with registered control outputs, one-cycle strobes and protocol assertions
`timescale 1ns/1ps

module nrisc_sequencer (
  input  logic                                    clk,
  input  logic                                    reset,
  // Requests from the decoder
  input  logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0]   alu_code,
  input  logic                                    inc_dec,
  input  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    dst,
  input  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    src1,
  input  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    src2,
  input  logic                                    imm_sel,
  input  logic                                    load_sel,
  input  logic                                    exec_write,
  input  logic [nrisc_ctrl_pkg::PHASE_W-1:0]      next_phase,
  input  logic [nrisc_ctrl_pkg::STACK_W-1:0]      stack_req,
  input  logic                                    is_store,
  // Datapath control
  output logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0]   alu_ctrl,
  output logic                                    inc_dec_sel,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    rd_addr,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    rf1_addr,
  output logic [nrisc_isa_pkg::REG_ADDR_W-1:0]    rf2_addr,
  output logic                                    imm_to_reg,
  output logic                                    data_to_reg,
  output logic                                    reg_write,
  output logic                                    data_addr_strobe,
  output logic                                    data_write,
  output logic [nrisc_ctrl_pkg::STACK_W-1:0]      stack_op,
  output logic [nrisc_ctrl_pkg::PHASE_W-1:0]      pc_sel,
  output logic                                    pc_strobe,
  output logic [nrisc_ctrl_pkg::PHASE_W-1:0]      phase
);

  // Phase register, selects and strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      phase            <= nrisc_ctrl_pkg::PH_EXEC;
      alu_ctrl         <= nrisc_ctrl_pkg::ALU_ADD;
      inc_dec_sel      <= 1'b0;
      imm_to_reg       <= 1'b0;
      data_to_reg      <= 1'b0;
      reg_write        <= 1'b0;
      data_addr_strobe <= 1'b0;
      data_write       <= 1'b0;
      stack_op         <= nrisc_ctrl_pkg::STK_NONE;
      pc_sel           <= nrisc_ctrl_pkg::PH_EXEC;
      pc_strobe        <= 1'b0;
    end else begin
      // Strobes drop back after one cycle
      reg_write        <= 1'b0;
      data_addr_strobe <= 1'b0;
      data_write       <= 1'b0;
      pc_strobe        <= 1'b0;
      stack_op         <= nrisc_ctrl_pkg::STK_NONE;

      case (phase)
        nrisc_ctrl_pkg::PH_EXEC: begin
          alu_ctrl    <= alu_code;
          inc_dec_sel <= inc_dec;
          imm_to_reg  <= imm_sel;
          data_to_reg <= load_sel;      // Held into PH_MEM for LW
          reg_write   <= exec_write;    // ALU class and LI
          stack_op    <= stack_req;
          pc_sel      <= nrisc_ctrl_pkg::PH_EXEC;  // PC + 1
          pc_strobe   <= 1'b1;
          phase       <= next_phase;
        end

        nrisc_ctrl_pkg::PH_MEM: begin
          data_addr_strobe <= 1'b1;     // Address from the execute-phase ALU result
          reg_write        <= load_sel; // LW data valid now
          if (is_store) begin
            // Pass the stored register through the ALU as src AND src
            alu_ctrl    <= nrisc_ctrl_pkg::ALU_AND;
            inc_dec_sel <= 1'b0;
            data_write  <= 1'b1;
          end
          phase <= nrisc_ctrl_pkg::PH_EXEC;
        end

        nrisc_ctrl_pkg::PH_JUMP: begin
          pc_sel    <= nrisc_ctrl_pkg::PH_JUMP;  // Load PC from ALU
          pc_strobe <= 1'b1;
          phase     <= nrisc_ctrl_pkg::PH_EXEC;
        end

        nrisc_ctrl_pkg::PH_RET: begin
          pc_sel    <= nrisc_ctrl_pkg::PH_RET;   // Load PC from stack top
          pc_strobe <= 1'b1;
          phase     <= nrisc_ctrl_pkg::PH_EXEC;
        end

        default: phase <= nrisc_ctrl_pkg::PH_EXEC;
      endcase
    end
  end

  // Register-file addresses
  always_ff @(posedge clk) begin
    if (phase == nrisc_ctrl_pkg::PH_EXEC) begin
      rd_addr  <= dst;
      rf1_addr <= src1;
      rf2_addr <= src2;
    end else if (phase == nrisc_ctrl_pkg::PH_MEM && is_store) begin
      // Both ALU ports read the register to store
      rf1_addr <= dst;
      rf2_addr <= dst;
    end
  end

  // Memory write only ever rides on an address strobe
  a_write_has_addr : assert property (
    @(posedge clk) disable iff (reset)
    data_write |-> data_addr_strobe
  ) else $error("data_write high without data_addr_strobe");

  // Register and memory writes are mutually exclusive
  a_write_exclusive : assert property (
    @(posedge clk) disable iff (reset)
    !(reg_write && data_write)
  ) else $error("reg_write and data_write high together");

  // Every second phase is followed by execute
  a_back_to_exec : assert property (
    @(posedge clk) disable iff (reset)
    (phase != nrisc_ctrl_pkg::PH_EXEC) |=> (phase == nrisc_ctrl_pkg::PH_EXEC)
  ) else $error("phase did not return to PH_EXEC");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f flist.f --top-module nrisc_ctrl_tb \
  -o nrisc_ctrl_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/nrisc_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

// File: tb/nrisc_ctrl_tb.sv
// Testbench for the control unit: clock, reset, stimulus, reference model and checking assertions
`timescale 1ns/1ps

module nrisc_ctrl_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int DIRECTED_N   = 256;  // 16 opcodes x 16 field values
  localparam int RANDOM_N     = 400;
  // Worst case two phases per instruction, plus a little slack
  localparam int PLAN_CYCLES  = RESET_CYCLES + 2 * (DIRECTED_N + RANDOM_N) + 8;
  localparam int WATCHDOG_NS  = PLAN_CYCLES * CLK_PERIOD * 3 / 2;
  localparam logic [31:0] RAND_SEED = 32'h4cf09610;

  logic                                  clk;
  logic                                  reset;
  nrisc_isa_pkg::instr_t                 instr_w;
  logic [nrisc_ctrl_pkg::FLAG_W-1:0]     flags;

  // DUT outputs
  logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0] alu_ctrl;
  logic                                  inc_dec_sel;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  rd_addr;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  rf1_addr;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  rf2_addr;
  logic                                  imm_to_reg;
  logic                                  data_to_reg;
  logic                                  reg_write;
  logic                                  data_addr_strobe;
  logic                                  data_write;
  logic [nrisc_ctrl_pkg::STACK_W-1:0]    stack_op;
  logic [nrisc_ctrl_pkg::PHASE_W-1:0]    pc_sel;
  logic                                  pc_strobe;
  logic [nrisc_ctrl_pkg::PHASE_W-1:0]    phase;

  // Expected requests for the word on the bus
  logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0] e_alu;
  logic                                  e_incdec;
  logic                                  e_write;
  logic                                  e_load;
  logic                                  e_store;
  logic [nrisc_ctrl_pkg::PHASE_W-1:0]    e_next;
  logic [nrisc_ctrl_pkg::STACK_W-1:0]    e_stack;
  logic                                  un_not;
  logic                                  un_step;  // INC or DEC
  logic                                  taken;

  // Model registers, updated on the same edge as the DUT
  logic [nrisc_ctrl_pkg::PHASE_W-1:0]    m_phase;
  logic [nrisc_ctrl_pkg::ALU_CTRL_W-1:0] m_alu;
  logic                                  m_incdec;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  m_rd;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  m_rf1;
  logic [nrisc_isa_pkg::REG_ADDR_W-1:0]  m_rf2;
  logic                                  m_addr_ok;  // Addresses loaded once out of reset
  logic                                  m_imm;
  logic                                  m_data;
  logic                                  m_regw;
  logic                                  m_das;
  logic                                  m_dw;
  logic [nrisc_ctrl_pkg::STACK_W-1:0]    m_stk;
  logic [nrisc_ctrl_pkg::PHASE_W-1:0]    m_pcsel;
  logic                                  m_pcs;

  int errors;
  int n_issued;

  nrisc_ctrl_top nrisc_ctrl_top_i (
    .clk (clk), .reset (reset), .instr (instr_w), .flags (flags),
    .alu_ctrl (alu_ctrl), .inc_dec_sel (inc_dec_sel), .rd_addr (rd_addr),
    .rf1_addr (rf1_addr), .rf2_addr (rf2_addr), .imm_to_reg (imm_to_reg),
    .data_to_reg (data_to_reg), .reg_write (reg_write),
    .data_addr_strobe (data_addr_strobe), .data_write (data_write),
    .stack_op (stack_op), .pc_sel (pc_sel), .pc_strobe (pc_strobe), .phase (phase)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Instruction classes straight from the encoding tables
  always_comb begin
    un_not   = instr_w.r.opcode == nrisc_isa_pkg::OP_UNARY
               && instr_w.r.src2 == nrisc_isa_pkg::UN_NOT;
    un_step  = instr_w.r.opcode == nrisc_isa_pkg::OP_UNARY
               && (instr_w.r.src2 == nrisc_isa_pkg::UN_INC
                   || instr_w.r.src2 == nrisc_isa_pkg::UN_DEC);
    e_incdec = un_step;
    e_load   = instr_w.r.opcode == nrisc_isa_pkg::OP_LW;
    e_store  = instr_w.r.opcode == nrisc_isa_pkg::OP_SW;
    // Bit 15 marks the ALU class, unary only for defined sub-opcodes
    e_write  = (instr_w.r.opcode[3] && (instr_w.r.opcode != nrisc_isa_pkg::OP_UNARY
                                        || un_not || un_step))
               || instr_w.r.opcode == nrisc_isa_pkg::OP_LI;
    case (instr_w.r.opcode)
      nrisc_isa_pkg::OP_SUB:   e_alu = nrisc_ctrl_pkg::ALU_SUB;
      nrisc_isa_pkg::OP_AND:   e_alu = nrisc_ctrl_pkg::ALU_AND;
      nrisc_isa_pkg::OP_OR:    e_alu = nrisc_ctrl_pkg::ALU_OR;
      nrisc_isa_pkg::OP_XOR:   e_alu = nrisc_ctrl_pkg::ALU_XOR;
      nrisc_isa_pkg::OP_SHR:   e_alu = nrisc_ctrl_pkg::ALU_SHR | {instr_w.r.src2[0], 3'b000};
      nrisc_isa_pkg::OP_SHL:   e_alu = nrisc_ctrl_pkg::ALU_SHL | {instr_w.r.src2[0], 3'b000};
      nrisc_isa_pkg::OP_UNARY: e_alu = un_not ? nrisc_ctrl_pkg::ALU_NOT
                                     : (instr_w.r.src2 == nrisc_isa_pkg::UN_DEC)
                                       ? nrisc_ctrl_pkg::ALU_SUB : nrisc_ctrl_pkg::ALU_ADD;
      default:                 e_alu = nrisc_ctrl_pkg::ALU_ADD;  // Adder for addresses
    endcase
    taken = instr_w.r.opcode == nrisc_isa_pkg::OP_JMP
            || (instr_w.r.opcode == nrisc_isa_pkg::OP_JZ && flags[nrisc_ctrl_pkg::FLAG_ZERO])
            || (instr_w.r.opcode == nrisc_isa_pkg::OP_JC && flags[nrisc_ctrl_pkg::FLAG_CARRY])
            || (instr_w.r.opcode == nrisc_isa_pkg::OP_JM && flags[nrisc_ctrl_pkg::FLAG_MINUS]);
    e_stack = nrisc_ctrl_pkg::STK_NONE;
    if (instr_w.s.opcode == nrisc_isa_pkg::OP_SYS) begin
      if (instr_w.s.sub == nrisc_isa_pkg::SYS_CALL)
        e_stack = nrisc_ctrl_pkg::STK_PUSH;
      else if (instr_w.s.sub == nrisc_isa_pkg::SYS_RET || instr_w.s.sub == nrisc_isa_pkg::SYS_RETI)
        e_stack = nrisc_ctrl_pkg::STK_POP;
    end
    if (e_load || e_store)                     e_next = nrisc_ctrl_pkg::PH_MEM;
    else if (taken || e_stack == nrisc_ctrl_pkg::STK_PUSH) e_next = nrisc_ctrl_pkg::PH_JUMP;
    else if (e_stack == nrisc_ctrl_pkg::STK_POP) e_next = nrisc_ctrl_pkg::PH_RET;
    else                                       e_next = nrisc_ctrl_pkg::PH_EXEC;
  end

  // Expected registered outputs
  always @(posedge clk) begin
    if (reset) begin
      m_phase   <= nrisc_ctrl_pkg::PH_EXEC;
      m_alu     <= nrisc_ctrl_pkg::ALU_ADD;
      m_incdec  <= 1'b0;
      m_imm     <= 1'b0;
      m_data    <= 1'b0;
      m_regw    <= 1'b0;
      m_das     <= 1'b0;
      m_dw      <= 1'b0;
      m_stk     <= nrisc_ctrl_pkg::STK_NONE;
      m_pcsel   <= nrisc_ctrl_pkg::PH_EXEC;
      m_pcs     <= 1'b0;
      m_addr_ok <= 1'b0;
    end else begin
      m_regw  <= 1'b0;
      m_das   <= 1'b0;
      m_dw    <= 1'b0;
      m_stk   <= nrisc_ctrl_pkg::STK_NONE;
      m_pcs   <= (m_phase != nrisc_ctrl_pkg::PH_MEM);  // Only the memory phase leaves PC alone
      m_phase <= nrisc_ctrl_pkg::PH_EXEC;
      if (m_phase != nrisc_ctrl_pkg::PH_MEM)
        m_pcsel <= m_phase;  // PC source is named by the phase code
      if (m_phase == nrisc_ctrl_pkg::PH_EXEC) begin
        m_alu     <= e_alu;
        m_incdec  <= e_incdec;
        m_imm     <= instr_w.r.opcode == nrisc_isa_pkg::OP_LI;
        m_data    <= e_load;
        m_regw    <= e_write;
        m_stk     <= e_stack;
        m_phase   <= e_next;
        m_rd      <= instr_w.r.dst;
        m_rf1     <= instr_w.r.src1;
        m_rf2     <= instr_w.r.src2;
        m_addr_ok <= 1'b1;
      end else if (m_phase == nrisc_ctrl_pkg::PH_MEM) begin
        m_das  <= 1'b1;
        m_regw <= e_load;   // LW data lands now
        if (e_store) begin
          m_alu    <= nrisc_ctrl_pkg::ALU_AND;
          m_incdec <= 1'b0;
          m_dw     <= 1'b1;
          m_rf1    <= instr_w.r.dst;
          m_rf2    <= instr_w.r.dst;
        end
      end
    end
  end

  task automatic log_mismatch(input string name, input int unsigned exp_v,
                              input int unsigned act_v);
    errors++;
    $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
  endtask

  task automatic count_rule_break(input string what);
    errors++;
    $display("[FAIL] t=%0t %s", $time, what);
  endtask

  // Output-by-output comparison against the model
  a_phase : assert property (@(posedge clk) disable iff (reset) phase == m_phase)
    else log_mismatch("phase", 32'($sampled(m_phase)), 32'($sampled(phase)));
  a_alu : assert property (@(posedge clk) disable iff (reset) alu_ctrl == m_alu)
    else log_mismatch("alu_ctrl", 32'($sampled(m_alu)), 32'($sampled(alu_ctrl)));
  a_incdec : assert property (@(posedge clk) disable iff (reset) inc_dec_sel == m_incdec)
    else log_mismatch("inc_dec_sel", 32'($sampled(m_incdec)), 32'($sampled(inc_dec_sel)));
  a_rd : assert property (@(posedge clk) disable iff (reset) m_addr_ok |-> rd_addr == m_rd)
    else log_mismatch("rd_addr", 32'($sampled(m_rd)), 32'($sampled(rd_addr)));
  a_rf1 : assert property (@(posedge clk) disable iff (reset) m_addr_ok |-> rf1_addr == m_rf1)
    else log_mismatch("rf1_addr", 32'($sampled(m_rf1)), 32'($sampled(rf1_addr)));
  a_rf2 : assert property (@(posedge clk) disable iff (reset) m_addr_ok |-> rf2_addr == m_rf2)
    else log_mismatch("rf2_addr", 32'($sampled(m_rf2)), 32'($sampled(rf2_addr)));
  a_imm : assert property (@(posedge clk) disable iff (reset) imm_to_reg == m_imm)
    else log_mismatch("imm_to_reg", 32'($sampled(m_imm)), 32'($sampled(imm_to_reg)));
  a_data : assert property (@(posedge clk) disable iff (reset) data_to_reg == m_data)
    else log_mismatch("data_to_reg", 32'($sampled(m_data)), 32'($sampled(data_to_reg)));
  a_regw : assert property (@(posedge clk) disable iff (reset) reg_write == m_regw)
    else log_mismatch("reg_write", 32'($sampled(m_regw)), 32'($sampled(reg_write)));
  a_das : assert property (@(posedge clk) disable iff (reset) data_addr_strobe == m_das)
    else log_mismatch("data_addr_strobe", 32'($sampled(m_das)), 32'($sampled(data_addr_strobe)));
  a_dw : assert property (@(posedge clk) disable iff (reset) data_write == m_dw)
    else log_mismatch("data_write", 32'($sampled(m_dw)), 32'($sampled(data_write)));
  a_stk : assert property (@(posedge clk) disable iff (reset) stack_op == m_stk)
    else log_mismatch("stack_op", 32'($sampled(m_stk)), 32'($sampled(stack_op)));
  a_pcsel : assert property (@(posedge clk) disable iff (reset) pc_sel == m_pcsel)
    else log_mismatch("pc_sel", 32'($sampled(m_pcsel)), 32'($sampled(pc_sel)));
  a_pcs : assert property (@(posedge clk) disable iff (reset) pc_strobe == m_pcs)
    else log_mismatch("pc_strobe", 32'($sampled(m_pcs)), 32'($sampled(pc_strobe)));

  // Outputs straight after reset
  a_reset_state : assert property (@(posedge clk) $fell(reset) |->
      (phase == nrisc_ctrl_pkg::PH_EXEC && !reg_write && !data_addr_strobe && !data_write
       && !pc_strobe && stack_op == nrisc_ctrl_pkg::STK_NONE
       && pc_sel == nrisc_ctrl_pkg::PH_EXEC && alu_ctrl == nrisc_ctrl_pkg::ALU_ADD
       && !imm_to_reg && !data_to_reg && !inc_dec_sel))
    else count_rule_break("outputs not at their reset values after reset");
  // SW passes the stored register through an AND
  a_store_path : assert property (@(posedge clk) disable iff (reset) data_write |->
      (alu_ctrl == nrisc_ctrl_pkg::ALU_AND && rf1_addr == rd_addr && rf2_addr == rd_addr))
    else count_rule_break("store did not read the stored register through ALU_AND");
  a_second_phase : assert property (@(posedge clk) disable iff (reset)
      phase != nrisc_ctrl_pkg::PH_EXEC |=> phase == nrisc_ctrl_pkg::PH_EXEC)
    else count_rule_break("second phase was not followed by the execute phase");

  // Present one word at a falling edge and wait for the return to execute
  task automatic issue_instr(input logic [15:0] word, input logic [2:0] f);
    instr_w = word;
    flags   = f;
    @(negedge clk);  // Execute edge done
    while (phase != nrisc_ctrl_pkg::PH_EXEC) @(negedge clk);
    n_issued++;
  endtask

  initial begin
    logic [31:0] rnd;
    errors   = 0;
    n_issued = 0;
    rnd      = $urandom(RAND_SEED);  // One seed for the whole run
    reset    = 1'b1;
    instr_w  = '0;
    flags    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Every opcode against every sub-opcode, unary slot and flag pattern
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 16; k++) begin
        rnd = $urandom();
        issue_instr({op[3:0], k[3:0], rnd[3:0], k[3:0]}, k[2:0]);
      end
    end
    repeat (RANDOM_N) begin
      rnd = $urandom();
      issue_instr(rnd[15:0], rnd[18:16]);
    end
    repeat (2) @(negedge clk);  // Let the last checks fire
    $display("%0d instructions, %0d errors", n_issued, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, instruction stream never completed", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

endmodule
